// ==== common/memory_defs.svh ====
// Size constants for the data memory.
// Include this wherever the word count or the lane count is needed.

`ifndef MEMORY_DEFS_SVH
`define MEMORY_DEFS_SVH

// Number of 32-bit words held by the data RAM
`define DATA_MEM_SIZE_WORDS 1024

// Bytes per memory word, one enable bit per byte lane
`define WORD_BYTES 4

`endif

// ==== common/riscv_pkg.sv ====
// Types seen on the core side of the load/store path.
// The encodings follow the RV32I load and store funct3 field.

`default_nettype none

package riscv_pkg;

  // Architectural register width of RV32I
  typedef logic [31:0] xword_t;

  // Access size as carried in funct3 of loads and stores
  typedef enum logic [2:0] {
    LDST_B  = 3'b000,  // Signed byte
    LDST_H  = 3'b001,  // Signed halfword
    LDST_W  = 3'b010,  // Full word
    LDST_BU = 3'b100,  // Unsigned byte
    LDST_HU = 3'b101   // Unsigned halfword
  } ldst_size_e;

  // One data access as issued by the core
  // Stores use all fields, loads ignore wdata
  typedef struct packed {
    logic       we;     // High for a store
    ldst_size_e size;
    xword_t     addr;   // Byte address
    xword_t     wdata;  // Store value in the low bits
  } core_req_t;

endpackage

`default_nettype wire

// ==== common/memory_pkg.sv ====
// Types seen on the memory side of the load/store path.
// Widths of the word and the byte enables follow the size defines.

`default_nettype none

`include "memory_defs.svh"

package memory_pkg;

  // Byte address as presented to the memory
  typedef logic [31:0] mem_addr_t;

  // One memory word, made of WORD_BYTES byte lanes
  typedef logic [8*`WORD_BYTES-1:0] mem_word_t;

  // Lane enables where bit n covers bits 8n+7 down to 8n
  typedef logic [`WORD_BYTES-1:0] mem_be_t;

  // Request as seen by the data RAM.
  // The address is always word aligned here since the load/store unit clears
  // the low bits before it drives the bus
  typedef struct packed {
    logic      we;     // High for a write
    mem_be_t   be;     // Lanes written on a store
    mem_addr_t addr;
    mem_word_t wdata;  // Already placed in its lanes
  } mem_req_t;

endpackage

`default_nettype wire

// ==== hw/lsu/lsu.sv ====
// Load/store unit between the core and the data memory.
// Places store data in its lanes, builds byte enables, stalls the core for
// the first cycle of every access and formats the returned load data.

`timescale 1ns/1ns
`default_nettype none

module lsu (
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,

  // Core side
  input  wire logic                  core_req_i,
  input  wire riscv_pkg::core_req_t  core_data_i,
  output memory_pkg::mem_word_t      core_rd_o,
  output logic                       core_stall_o,

  // Memory side
  output logic                       mem_req_o,
  output memory_pkg::mem_req_t       mem_data_o,
  input  wire memory_pkg::mem_word_t mem_rd_i,
  input  wire logic                  mem_ready_i
);

  typedef enum logic {
    LSU_IDLE = 1'b0,  // Ready to accept a request
    LSU_WAIT = 1'b1   // Response cycle after the memory access
  } lsu_state_e;

  lsu_state_e state_q;
  lsu_state_e state_d;

  logic [1:0]            st_off;   // Byte offset of the current request
  memory_pkg::mem_be_t   st_be;
  memory_pkg::mem_word_t st_data;

  // Load formatting needs the size and offset after the request is gone
  riscv_pkg::ldst_size_e ld_size_q;
  logic [1:0]            ld_off_q;
  logic [7:0]            ld_byte;
  logic [15:0]           ld_half;

  // Stall FSM

  always_comb begin
    state_d = state_q;
    case (state_q)
      LSU_IDLE: begin
        if (core_req_i) begin
          state_d = LSU_WAIT;
        end
      end
      LSU_WAIT: begin
        if (mem_ready_i) begin
          state_d = LSU_IDLE;  // Core sees the stall drop in this cycle
        end
      end
      default: state_d = LSU_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= LSU_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // A new request stalls for one cycle and a slow memory keeps the stall up
  assign core_stall_o = ((state_q == LSU_IDLE) && core_req_i) ||
                        ((state_q == LSU_WAIT) && !mem_ready_i);

  // The memory is only hit in the first cycle so a store lands once
  assign mem_req_o = (state_q == LSU_IDLE) && core_req_i;

  // Store lane placement

  assign st_off = core_data_i.addr[1:0];

  always_comb begin
    case (core_data_i.size)
      riscv_pkg::LDST_B,
      riscv_pkg::LDST_BU: begin
        st_be   = memory_pkg::mem_be_t'(4'b0001 << st_off);
        st_data = {4{core_data_i.wdata[7:0]}};   // Every lane gets the byte
      end
      riscv_pkg::LDST_H,
      riscv_pkg::LDST_HU: begin
        // Bit 0 of the address is ignored for halfwords
        st_be   = st_off[1] ? 4'b1100 : 4'b0011;
        st_data = {2{core_data_i.wdata[15:0]}};
      end
      default: begin
        st_be   = 4'b1111;
        st_data = core_data_i.wdata;
      end
    endcase
  end

  always_comb begin
    mem_data_o.we    = core_data_i.we;
    mem_data_o.be    = st_be;
    mem_data_o.addr  = {core_data_i.addr[31:2], 2'b00};  // Word aligned
    mem_data_o.wdata = st_data;
  end

  // Load extraction

  // Size and offset are captured with the request
  always_ff @(posedge clk_i) begin
    if (mem_req_o) begin
      ld_size_q <= core_data_i.size;
      ld_off_q  <= st_off;
    end
  end

  assign ld_byte = mem_rd_i[8*ld_off_q +: 8];
  assign ld_half = ld_off_q[1] ? mem_rd_i[31:16] : mem_rd_i[15:0];

  always_comb begin
    case (ld_size_q)
      riscv_pkg::LDST_B:  core_rd_o = {{24{ld_byte[7]}}, ld_byte};
      riscv_pkg::LDST_H:  core_rd_o = {{16{ld_half[15]}}, ld_half};
      riscv_pkg::LDST_BU: core_rd_o = {24'h0, ld_byte};
      riscv_pkg::LDST_HU: core_rd_o = {16'h0, ld_half};
      default:            core_rd_o = mem_rd_i;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/data_mem.sv ====
// Synchronous data RAM with per-byte write enables.
// Reads have one cycle of latency and the read register holds between reads.

`timescale 1ns/1ns
`default_nettype none

`include "memory_defs.svh"

module data_mem (
  input  wire logic                  clk_i,
  input  wire logic                  mem_req_i,
  input  wire memory_pkg::mem_req_t  mem_data_i,
  output memory_pkg::mem_word_t      mem_rd_o,
  output logic                       mem_ready_o
);

  localparam int unsigned IDX_W = $clog2(`DATA_MEM_SIZE_WORDS);

  memory_pkg::mem_word_t ram [`DATA_MEM_SIZE_WORDS];

  logic [IDX_W-1:0] word_idx;
  logic             wr_en;
  logic             rd_en;

  // Upper address bits are dropped so the memory wraps around
  assign word_idx = mem_data_i.addr[IDX_W+1:2];

  assign wr_en = mem_req_i && mem_data_i.we;
  assign rd_en = mem_req_i && !mem_data_i.we;

  // Only lanes with their enable set are written
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int lane = 0; lane < `WORD_BYTES; lane++) begin
        if (mem_data_i.be[lane]) begin
          ram[word_idx][8*lane +: 8] <= mem_data_i.wdata[8*lane +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      mem_rd_o <= ram[word_idx];  // Held on writes and idle cycles
    end
  end

  // This RAM answers every access in a fixed time
  assign mem_ready_o = 1'b1;

endmodule

`default_nettype wire

// ==== hw/mem_subsystem_top.sv ====
// Data side of the core: the load/store unit in front of the data RAM.
// The core talks to this block and never sees the memory bus directly.

`timescale 1ns/1ns
`default_nettype none

module mem_subsystem_top (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 core_req_i,
  input  wire riscv_pkg::core_req_t core_data_i,
  output memory_pkg::mem_word_t     core_rd_o,
  output logic                      core_stall_o
);

  // Memory bus between the unit and the RAM
  logic                  mem_req;
  memory_pkg::mem_req_t  mem_data;
  memory_pkg::mem_word_t mem_rd;
  logic                  mem_ready;

  lsu u_lsu (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .core_req_i   (core_req_i),
    .core_data_i  (core_data_i),
    .core_rd_o    (core_rd_o),
    .core_stall_o (core_stall_o),
    .mem_req_o    (mem_req),
    .mem_data_o   (mem_data),
    .mem_rd_i     (mem_rd),
    .mem_ready_i  (mem_ready)
  );

  // The RAM has no reset, its contents are undefined until written
  data_mem u_data_mem (
    .clk_i       (clk_i),
    .mem_req_i   (mem_req),
    .mem_data_i  (mem_data),
    .mem_rd_o    (mem_rd),
    .mem_ready_o (mem_ready)
  );

endmodule

`default_nettype wire

// ==== dv/tb_mem_subsystem.sv ====
// Self-checking testbench for the load/store unit and data RAM.
// Random accesses are mirrored in a shadow byte array and checked by assertions.

`timescale 1ns/1ns
`default_nettype none

`include "memory_defs.svh"

module tb_mem_subsystem;

  localparam int unsigned WRAP_BYTES = `DATA_MEM_SIZE_WORDS * 4;
  localparam int N_INIT = 64;   // One word store per tested word
  localparam int N_RAND = 160;  // Each iteration does a store, a load and a word load
  localparam int N_WRAP = 16;
  // About 600 accesses at 2 or 3 cycles each plus idle gaps and margin
  localparam int TIMEOUT_CYCLES = 4000;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  core_req_i;
  riscv_pkg::core_req_t  core_data_i;
  memory_pkg::mem_word_t core_rd_o;
  logic                  core_stall_o;

  logic [7:0]  shadow [256];  // Bytes of the first 64 RAM words
  logic [31:0] lfsr_state;
  logic        chk_load;      // High in the response cycle of a load
  logic [31:0] exp_rd;
  int          err_cnt;
  int          access_cnt;
  int          load_cnt;
  int          cycle_cnt;

  mem_subsystem_top DUT (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .core_req_i   (core_req_i),
    .core_data_i  (core_data_i),
    .core_rd_o    (core_rd_o),
    .core_stall_o (core_stall_o)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // Each bit is taken from bit 0 before one Galois shift
  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return val;
  endfunction

  // Word index after the RAM wraps the address
  function automatic int unsigned shadow_word(input logic [31:0] addr);
    return (addr % WRAP_BYTES) / 4;
  endfunction

  function automatic void apply_store(input riscv_pkg::ldst_size_e size,
                                      input logic [31:0] addr, input logic [31:0] wdata);
    int unsigned base;
    base = shadow_word(addr) * 4;
    case (size)
      riscv_pkg::LDST_B, riscv_pkg::LDST_BU: shadow[base + addr[1:0]] = wdata[7:0];
      riscv_pkg::LDST_H, riscv_pkg::LDST_HU: begin
        shadow[base + 2 * addr[1]]     = wdata[7:0];
        shadow[base + 2 * addr[1] + 1] = wdata[15:8];
      end
      default: begin
        for (int lane = 0; lane < 4; lane++) begin
          shadow[base + lane] = wdata[8*lane +: 8];
        end
      end
    endcase
  endfunction

  function automatic logic [31:0] expected_load(input riscv_pkg::ldst_size_e size,
                                                input logic [31:0] addr);
    int unsigned base;
    logic [7:0]  b;
    logic [15:0] h;
    base = shadow_word(addr) * 4;
    b = shadow[base + addr[1:0]];
    h = {shadow[base + 2 * addr[1] + 1], shadow[base + 2 * addr[1]]};
    case (size)
      riscv_pkg::LDST_B:  return {{24{b[7]}}, b};
      riscv_pkg::LDST_H:  return {{16{h[15]}}, h};
      riscv_pkg::LDST_BU: return {24'h0, b};
      riscv_pkg::LDST_HU: return {16'h0, h};
      default: return {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
    endcase
  endfunction

  function automatic riscv_pkg::ldst_size_e pick_load_size();
    case (take_bits(3))
      0, 6:    return riscv_pkg::LDST_B;
      1, 7:    return riscv_pkg::LDST_H;
      3:       return riscv_pkg::LDST_BU;
      4:       return riscv_pkg::LDST_HU;
      default: return riscv_pkg::LDST_W;
    endcase
  endfunction

  function automatic riscv_pkg::ldst_size_e pick_store_size();
    case (take_bits(2))
      0:       return riscv_pkg::LDST_B;
      1:       return riscv_pkg::LDST_H;
      default: return riscv_pkg::LDST_W;
    endcase
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
      core_req_i = 1'b0;
      chk_load   = 1'b0;
    end
  endtask

  // One access held until the stall drops. Some accesses keep the request up
  // through the whole response cycle, as a core that samples the stall would
  task automatic do_access(input logic we, input riscv_pkg::ldst_size_e size,
                           input logic [31:0] addr, input logic [31:0] wdata);
    logic hold;
    hold = (take_bits(1) != 0);
    @(posedge clk_i);
    #1;
    chk_load          = 1'b0;
    core_req_i        = 1'b1;
    core_data_i.we    = we;
    core_data_i.size  = size;
    core_data_i.addr  = addr;
    core_data_i.wdata = wdata;
    if (we) begin
      apply_store(size, addr, wdata);
    end
    do begin
      @(posedge clk_i);
      #1;
    end while (core_stall_o);
    if (!we) begin
      exp_rd   = expected_load(size, addr);
      chk_load = 1'b1;
      load_cnt++;
    end
    if (hold) begin
      @(posedge clk_i);
      #1;
      chk_load = 1'b0;
    end
    core_req_i = 1'b0;
    access_cnt++;
  endtask

  stall_first: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(core_req_i) |-> core_stall_o)
    else begin
      err_cnt++;
      $display("[ERROR] %0t: stall low in the first cycle of a request", $time);
    end

  stall_second: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(core_req_i) |=> !core_stall_o)
    else begin
      err_cnt++;
      $display("[ERROR] %0t: stall still high in the second cycle", $time);
    end

  stall_idle: assert property (@(posedge clk_i) !core_req_i |-> !core_stall_o)
    else begin
      err_cnt++;
      $display("[ERROR] %0t: stall high with no request", $time);
    end

  single_mem_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    DUT.mem_req |=> !DUT.mem_req)
    else begin
      err_cnt++;
      $display("[ERROR] %0t: memory request held for more than one cycle", $time);
    end

  load_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    chk_load |-> core_rd_o == exp_rd)
    else begin
      err_cnt++;
      $display("[ERROR] %0t: load data %h, expected %h", $time, core_rd_o, exp_rd);
    end

  initial begin
    logic [5:0]            word;
    logic [1:0]            off;
    logic [31:0]           data;
    logic [19:0]           hi;
    riscv_pkg::ldst_size_e size;
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    core_req_i  = 1'b0;
    core_data_i = '0;
    chk_load    = 1'b0;
    exp_rd      = '0;
    err_cnt     = 0;
    access_cnt  = 0;
    load_cnt    = 0;
    cycle_cnt   = 0;
    lfsr_state  = 32'd34;
    repeat (5) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    idle_cycles(3);

    // Fill every tested word so no load returns unknown bytes
    for (int i = 0; i < N_INIT; i++) begin
      do_access(1'b1, riscv_pkg::LDST_W, {24'h0, 6'(i), 2'(take_bits(2))}, take_bits(32));
    end
    for (int i = 0; i < N_RAND; i++) begin
      word = take_bits(6);
      off  = take_bits(2);
      size = pick_store_size();
      data = take_bits(32);
      do_access(1'b1, size, {24'h0, word, off}, data);
      off  = take_bits(2);
      size = pick_load_size();
      do_access(1'b0, size, {24'h0, word, off}, '0);
      do_access(1'b0, riscv_pkg::LDST_W, {24'h0, word, 2'(take_bits(2))}, '0);  // Neighbours
      if (take_bits(2) == 0) begin
        idle_cycles(1 + take_bits(2));
      end
    end

    // Upper address bits beyond the RAM size must be dropped
    for (int i = 0; i < N_WRAP; i++) begin
      word = take_bits(6);
      hi   = take_bits(20) | 20'h1;
      data = take_bits(32);
      do_access(1'b1, riscv_pkg::LDST_W, {hi, 4'h0, word, 2'b00}, data);
      do_access(1'b0, riscv_pkg::LDST_W, {24'h0, word, 2'b00}, '0);
    end
    idle_cycles(3);

    $display("Accesses: %0d, loads checked: %0d, errors: %0d", access_cnt, load_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+common
common/riscv_pkg.sv
common/memory_pkg.sv
hw/lsu/lsu.sv
hw/data_mem.sv
hw/mem_subsystem_top.sv
dv/tb_mem_subsystem.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/riscv_pkg.sv
      - common/memory_pkg.sv
      - hw/lsu/lsu.sv
      - hw/data_mem.sv
      - hw/mem_subsystem_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - dv/tb_mem_subsystem.sv
